// File: uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// frame format, fixed for the whole design
`define UART_DATA_WIDTH   8    // data bits per frame
`define UART_PARITY_ODD   0    // 0 even, 1 odd

// bit timing in tx_clk cycles
`define UART_CLKS_PER_BIT 8    // cycles per serial bit, even so mid-bit is exact

// receive front end
`define UART_SYNC_STAGES  3    // flops between the line and the sampler

// start + data + parity + stop
`define UART_FRAME_BITS   (`UART_DATA_WIDTH + 3)

`endif

// File: uart_pkg.sv
`include "uart_config.svh"

package uart_pkg;

	// field view of one frame, start bit sits at bit 0 so it leaves first
	typedef struct packed {
		logic                        stop_bit;    // always 1 on transmit
		logic                        parity_bit;  // per UART_PARITY_ODD
		logic [`UART_DATA_WIDTH-1:0] data;        // sent lsb first
		logic                        start_bit;   // always 0 on transmit
	} frame_fields_t;

	// same 11 bits seen as a shift register
	typedef union packed {
		frame_fields_t               fields;  // written when a word is loaded
		logic [`UART_FRAME_BITS-1:0] raw;     // shifted right once per bit period
	} frame_t;

	// sampler position inside a frame
	typedef enum logic [2:0] {
		RX_IDLE,    // waiting for a falling edge
		RX_START,   // counting to the middle of the start bit
		RX_DATA,    // one sample per data bit
		RX_PARITY,  // parity bit sample
		RX_STOP     // stop bit sample, then back to idle
	} rx_state_t;

endpackage

// File: rx_bit_if.sv
`timescale 1ns/100ps

interface rx_bit_if;

	logic bit_strobe;   // high one cycle per sampled bit
	logic bit_value;    // line level taken at mid-bit
	logic frame_start;  // this strobe is the start bit
	logic frame_end;    // this strobe is the stop bit

	// sampler drives, deframer consumes, no back-pressure
	modport sampler (
		output bit_strobe, bit_value, frame_start, frame_end
	);

	modport deframer (
		input  bit_strobe, bit_value, frame_start, frame_end
	);

endinterface

// File: uart_tx.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_tx (
	input  logic                        tx_clk,
	input  logic                        reset_tx,
	input  logic                        i_enable,      // request, taken only while idle
	input  logic [`UART_DATA_WIDTH-1:0] i_data,        // word to send, sampled with i_enable
	output logic                        o_busy,        // high for the whole frame
	output logic                        o_serial_out   // serial line, idles high
);

	localparam int CLK_W = $clog2(`UART_CLKS_PER_BIT);
	localparam int BIT_W = $clog2(`UART_FRAME_BITS + 1);

	uart_pkg::frame_t load_frame;   // frame built from i_data
	uart_pkg::frame_t tx_frame;     // remaining bits, bit 0 is on the line
	logic [CLK_W-1:0] clk_cnt;      // cycle within the current bit
	logic [BIT_W-1:0] bit_cnt;      // index of the bit on the line, 0 = start
	logic             bit_done;     // last cycle of the current bit
	logic             last_bit;     // stop bit is on the line
	logic             accept;       // enable seen while idle

	assign accept   = i_enable && !o_busy;
	assign bit_done = (clk_cnt == CLK_W'(`UART_CLKS_PER_BIT - 1));
	assign last_bit = (bit_cnt == BIT_W'(`UART_FRAME_BITS - 1));

	// fill the frame through its field view
	always_comb begin
		load_frame.fields.start_bit  = 1'b0;
		load_frame.fields.data       = i_data;
		load_frame.fields.parity_bit = (^i_data) ^ 1'(`UART_PARITY_ODD);  // odd flips it
		load_frame.fields.stop_bit   = 1'b1;
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			o_busy       <= 1'b0;
			o_serial_out <= 1'b1;   // line idles at mark
			clk_cnt      <= '0;
			bit_cnt      <= '0;
		end else if (accept) begin
			o_busy       <= 1'b1;
			o_serial_out <= load_frame.raw[0];   // start bit from next cycle
			clk_cnt      <= '0;
			bit_cnt      <= '0;
		end else if (o_busy) begin
			clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
			if (bit_done) begin
				if (last_bit) begin
					o_busy       <= 1'b0;   // 11 bits x 8 cycles done
					o_serial_out <= 1'b1;
					bit_cnt      <= '0;
				end else begin
					o_serial_out <= tx_frame.raw[1];   // next bit, lsb first
					bit_cnt      <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// frame shifts right in step with o_serial_out
	always_ff @(posedge tx_clk) begin
		if (accept) begin
			tx_frame <= load_frame;
		end else if (o_busy && bit_done) begin
			tx_frame.raw <= tx_frame.raw >> 1;
		end
	end

	// between frames the line must sit at stop level
	a_idle_line_high: assert property (@(posedge tx_clk) disable iff (reset_tx)
		!o_busy |-> o_serial_out);

	a_bit_cnt_range: assert property (@(posedge tx_clk) disable iff (reset_tx)
		bit_cnt <= BIT_W'(`UART_FRAME_BITS));

endmodule

// File: rx_sampler.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module rx_sampler (
	input  logic      tx_clk,
	input  logic      reset_tx,
	input  logic      i_serial_in,   // line from the far end, unsynchronized
	rx_bit_if.sampler o_bits         // one strobe per bit period
);

	localparam int CLK_W  = $clog2(`UART_CLKS_PER_BIT);
	localparam int DATA_W = $clog2(`UART_DATA_WIDTH);

	logic [`UART_SYNC_STAGES-1:0] sync_q;   // synchronizer chain
	logic                         rx_sync;  // synchronized line
	logic                         rx_prev;  // rx_sync one cycle back
	logic                         start_edge;
	logic                         sample_tick;
	logic [CLK_W-1:0]             clk_cnt;  // position inside the bit
	logic [DATA_W-1:0]            data_cnt; // data bit being sampled
	uart_pkg::rx_state_t          state;

	assign rx_sync     = sync_q[`UART_SYNC_STAGES-1];
	assign start_edge  = rx_prev && !rx_sync;   // mark to space
	assign sample_tick = (clk_cnt == CLK_W'(`UART_CLKS_PER_BIT - 1));

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q  <= '1;   // assume idle line
			rx_prev <= 1'b1;
		end else begin
			sync_q  <= {sync_q[`UART_SYNC_STAGES-2:0], i_serial_in};
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state              <= uart_pkg::RX_IDLE;
			clk_cnt            <= '0;
			data_cnt           <= '0;
			o_bits.bit_strobe  <= 1'b0;
			o_bits.frame_start <= 1'b0;
			o_bits.frame_end   <= 1'b0;
		end else begin
			o_bits.bit_strobe  <= 1'b0;
			o_bits.frame_start <= 1'b0;
			o_bits.frame_end   <= 1'b0;
			clk_cnt            <= sample_tick ? '0 : clk_cnt + 1'b1;
			case (state)
				uart_pkg::RX_IDLE: begin
					if (start_edge) begin
						state   <= uart_pkg::RX_START;
						clk_cnt <= CLK_W'(`UART_CLKS_PER_BIT / 2);   // tick lands mid-bit
					end
				end
				uart_pkg::RX_START: begin
					if (sample_tick) begin
						if (rx_sync) begin
							state <= uart_pkg::RX_IDLE;   // glitch, nothing sent on
						end else begin
							state              <= uart_pkg::RX_DATA;
							data_cnt           <= '0;
							o_bits.bit_strobe  <= 1'b1;
							o_bits.frame_start <= 1'b1;
						end
					end
				end
				uart_pkg::RX_DATA: begin
					if (sample_tick) begin
						o_bits.bit_strobe <= 1'b1;
						data_cnt          <= data_cnt + 1'b1;
						if (data_cnt == DATA_W'(`UART_DATA_WIDTH - 1))
							state <= uart_pkg::RX_PARITY;
					end
				end
				uart_pkg::RX_PARITY: begin
					if (sample_tick) begin
						o_bits.bit_strobe <= 1'b1;
						state             <= uart_pkg::RX_STOP;
					end
				end
				uart_pkg::RX_STOP: begin
					if (sample_tick) begin
						o_bits.bit_strobe <= 1'b1;
						o_bits.frame_end  <= 1'b1;
						state             <= uart_pkg::RX_IDLE;   // rearm in mid stop bit
					end
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// level captured on every tick, only meaningful with bit_strobe
	always_ff @(posedge tx_clk) begin
		if (sample_tick)
			o_bits.bit_value <= rx_sync;
	end

	a_strobe_single: assert property (@(posedge tx_clk) disable iff (reset_tx)
		o_bits.bit_strobe |=> !o_bits.bit_strobe);

endmodule

// File: rx_deframer.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module rx_deframer (
	input  logic                        tx_clk,
	input  logic                        reset_tx,
	rx_bit_if.deframer                  i_bits,           // sampled bits from the front end
	output logic [`UART_DATA_WIDTH-1:0] o_received_data,  // held until the next valid
	output logic                        o_data_valid,     // one-cycle strobe per frame
	output logic                        o_rx_error        // parity or stop fault
);

	localparam int CNT_W = $clog2(`UART_DATA_WIDTH + 1);

	logic [`UART_DATA_WIDTH-1:0] data_sr;     // data bits, lsb arrives first
	logic [CNT_W-1:0]            bit_cnt;     // data bits taken so far
	logic                        parity_acc;  // xor of data and parity bits
	logic                        data_bit;    // next middle strobe is a data bit
	logic                        mid_bit;     // strobe between start and stop
	logic                        frame_bad;   // checked on the stop strobe

	assign data_bit  = (bit_cnt < CNT_W'(`UART_DATA_WIDTH));
	assign mid_bit   = i_bits.bit_strobe && !i_bits.frame_start && !i_bits.frame_end;
	// even parity leaves the xor at 0, odd at 1
	assign frame_bad = !i_bits.bit_value || (parity_acc != 1'(`UART_PARITY_ODD));

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			bit_cnt         <= '0;
			parity_acc      <= 1'b0;
			o_data_valid    <= 1'b0;
			o_rx_error      <= 1'b0;
			o_received_data <= '0;
		end else begin
			o_data_valid <= 1'b0;
			if (i_bits.bit_strobe && i_bits.frame_start) begin
				bit_cnt    <= '0;   // fresh frame
				parity_acc <= 1'b0;
			end else if (i_bits.bit_strobe && i_bits.frame_end) begin
				o_data_valid    <= 1'b1;
				o_received_data <= data_sr;
				o_rx_error      <= frame_bad;   // bit_value is the stop bit here
			end else if (mid_bit) begin
				parity_acc <= parity_acc ^ i_bits.bit_value;   // data and parity alike
				if (data_bit)
					bit_cnt <= bit_cnt + 1'b1;   // stops at data width for the parity bit
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (mid_bit && data_bit)
			data_sr <= {i_bits.bit_value, data_sr[`UART_DATA_WIDTH-1:1]};
	end

	a_valid_pulse: assert property (@(posedge tx_clk) disable iff (reset_tx)
		o_data_valid |=> !o_data_valid);

endmodule

// File: uart_loopback.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_loopback (
	input  logic                        tx_clk,
	input  logic                        reset_tx,
	input  logic                        i_enable,         // start a frame when not busy
	input  logic [`UART_DATA_WIDTH-1:0] i_data,
	output logic                        o_busy,
	output logic                        o_serial_out,     // transmit line
	input  logic                        i_serial_in,      // receive line, looped outside
	output logic [`UART_DATA_WIDTH-1:0] o_received_data,
	output logic                        o_data_valid,
	output logic                        o_rx_error
);

	rx_bit_if rx_bits ();   // sampler to deframer

	uart_tx u_tx (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.o_busy       (o_busy),
		.o_serial_out (o_serial_out)
	);

	rx_sampler u_sampler (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_serial_in (i_serial_in),
		.o_bits      (rx_bits)
	);

	rx_deframer u_deframer (
		.tx_clk          (tx_clk),
		.reset_tx        (reset_tx),
		.i_bits          (rx_bits),
		.o_received_data (o_received_data),
		.o_data_valid    (o_data_valid),
		.o_rx_error      (o_rx_error)
	);

endmodule

// File: tb_uart_loopback.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module tb_uart_loopback;

	localparam int NUM_ROWS       = 12;
	localparam int ROW_CYCLES     = 120;   // budget per row covers 88 frame cycles and rx latency
	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * ROW_CYCLES + RESET_CYCLES;
	localparam int CPB            = `UART_CLKS_PER_BIT;
	localparam int DW             = `UART_DATA_WIDTH;
	localparam int BUSY_CYCLES    = `UART_FRAME_BITS * `UART_CLKS_PER_BIT;
	localparam int QUIET_CYCLES   = 12;    // watch for a stray frame after each row
	localparam logic [31:0] LCG_SEED = 32'h472e7c97;

	localparam int CORRUPT_NONE   = 0;
	localparam int CORRUPT_PARITY = 1;     // invert the parity bit on the way back
	localparam int CORRUPT_STOP   = 2;     // force the stop bit low

	logic          tx_clk;
	logic          reset_tx;
	logic          i_enable;
	logic [DW-1:0] i_data;
	logic          o_busy;
	logic          o_serial_out;
	logic          i_serial_in;
	logic [DW-1:0] o_received_data;
	logic          o_data_valid;
	logic          o_rx_error;

	string         row_name [NUM_ROWS];
	logic [DW-1:0] row_data [NUM_ROWS];
	int            row_kind [NUM_ROWS];
	bit            row_pulse[NUM_ROWS];   // extra enable while busy
	logic [31:0]   lcg_state;
	int            errors;
	int            frames;
	int            cycle_cnt = 0;

	uart_loopback DUT (
		.tx_clk          (tx_clk),
		.reset_tx        (reset_tx),
		.i_enable        (i_enable),
		.i_data          (i_data),
		.o_busy          (o_busy),
		.o_serial_out    (o_serial_out),
		.i_serial_in     (i_serial_in),
		.o_received_data (o_received_data),
		.o_data_valid    (o_data_valid),
		.o_rx_error      (o_rx_error)
	);

	initial begin
		tx_clk = 1'b0;
		forever #5 tx_clk = ~tx_clk;   // 10 ns period
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// bit k of a frame where 0 is start and DW+2 is stop
	function automatic logic expected_bit(input logic [DW-1:0] data, input int k);
		logic par;
		int   i;
		par = 1'(`UART_PARITY_ODD);   // odd parity inverts the xor
		for (i = 0; i < DW; i++)
			par = par ^ data[i];
		if (k == 0)
			return 1'b0;
		else if (k <= DW)
			return data[k-1];   // lsb first
		else if (k == DW + 1)
			return par;
		else
			return 1'b1;
	endfunction

	task automatic report_mismatch(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("ERROR %s %s: expected %0h actual %0h", name, what, exp, act);
	endtask

	task automatic set_row(input int idx, input string name, input logic [DW-1:0] data,
		input int kind);
		row_name[idx] = name;
		row_data[idx] = data;
		row_kind[idx] = kind;
	endtask

	task automatic fill_table();
		int i;
		set_row(0, "zeros", 8'h00, CORRUPT_NONE);
		set_row(1, "ones", 8'hff, CORRUPT_NONE);
		set_row(2, "par_55", 8'h55, CORRUPT_PARITY);
		set_row(3, "alt_aa", 8'haa, CORRUPT_NONE);
		set_row(4, "stop_3c", 8'h3c, CORRUPT_STOP);
		set_row(5, "one_bit", 8'h01, CORRUPT_NONE);
		for (i = 6; i < NUM_ROWS; i++) begin
			lcg_state = lcg_next(lcg_state);
			set_row(i, $sformatf("lcg_%0d", i), lcg_state[23:16],   // upper bits of an lcg mix better
				(i == 8) ? CORRUPT_PARITY : (i == 10) ? CORRUPT_STOP : CORRUPT_NONE);
		end
		for (i = 0; i < NUM_ROWS; i++)
			row_pulse[i] = i[0];   // odd rows try a mid-frame enable
	endtask

	task automatic check_reset_state();
		repeat (4) @(negedge tx_clk);
		if (o_busy !== 1'b0)
			report_mismatch("reset", "o_busy", 0, o_busy);
		if (o_serial_out !== 1'b1)
			report_mismatch("reset", "o_serial_out", 1, o_serial_out);
		if (o_data_valid !== 1'b0)
			report_mismatch("reset", "o_data_valid", 0, o_data_valid);
		if (o_rx_error !== 1'b0)
			report_mismatch("reset", "o_rx_error", 0, o_rx_error);
		if (o_received_data !== '0)
			report_mismatch("reset", "data", 0, o_received_data);
	endtask

	// sends one frame out and back starting at a falling edge
	task automatic run_row(input int idx);
		string name;
		int    tick;
		int    k;
		int    busy_cnt;
		int    valids;
		int    quiet;
		logic  tx_done;
		logic  line;
		name     = row_name[idx];
		tick     = 0;
		busy_cnt = 0;
		valids   = 0;
		quiet    = 0;
		tx_done  = 1'b0;
		if (o_busy !== 1'b0) report_mismatch(name, "busy before enable", 0, o_busy);
		i_data   = row_data[idx];
		i_enable = 1'b1;
		while (!tx_done || valids == 0 || quiet < QUIET_CYCLES) begin
			@(negedge tx_clk);
			tick++;
			i_enable = 1'b0;
			k        = (tick - 1) / CPB;   // bit window on the line
			if (tick == 1 && o_busy !== 1'b1)
				report_mismatch(name, "busy rise", 1, o_busy);
			if (o_busy)
				busy_cnt++;
			else
				tx_done = 1'b1;
			if (row_pulse[idx] && tick == 40) begin
				i_enable = 1'b1;   // must be ignored while busy
				i_data   = ~row_data[idx];
			end
			if (tick <= BUSY_CYCLES && (tick - 1) % CPB == CPB / 2 - 1) begin
				if (o_serial_out !== expected_bit(row_data[idx], k))
					report_mismatch(name, $sformatf("frame bit %0d", k),
						expected_bit(row_data[idx], k), o_serial_out);
			end
			line = o_serial_out;
			if (tick <= BUSY_CYCLES && row_kind[idx] == CORRUPT_PARITY && k == DW + 1)
				line = ~line;
			if (tick <= BUSY_CYCLES && row_kind[idx] == CORRUPT_STOP && k == DW + 2)
				line = 1'b0;
			i_serial_in = line;
			if (o_data_valid) begin
				valids++;
				frames++;
				if (o_received_data !== row_data[idx])
					report_mismatch(name, "data", row_data[idx], o_received_data);
				if (o_rx_error !== (row_kind[idx] != CORRUPT_NONE))
					report_mismatch(name, "rx_error", row_kind[idx] != CORRUPT_NONE, o_rx_error);
			end
			if (tx_done && valids > 0)
				quiet++;
		end
		if (busy_cnt != BUSY_CYCLES)
			report_mismatch(name, "busy cycles", BUSY_CYCLES, busy_cnt);
		if (valids != 1)
			report_mismatch(name, "valid pulses", 1, valids);
	endtask

	always @(posedge tx_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		reset_tx    = 1'b1;
		i_enable    = 1'b0;
		i_data      = '0;
		i_serial_in = 1'b1;   // idle line
		errors      = 0;
		frames      = 0;
		lcg_state   = LCG_SEED;
		fill_table();
		repeat (RESET_CYCLES) @(negedge tx_clk);
		reset_tx = 1'b0;
		check_reset_state();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("summary: %0d errors, %0d of %0d frames received", errors, frames, NUM_ROWS);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: uart_loopback.f
+incdir+.
uart_pkg.sv
rx_bit_if.sv
uart_tx.sv
rx_sampler.sv
rx_deframer.sv
uart_loopback.sv
tb_uart_loopback.sv

// File: Bender.yml
package:
  name: uart_loopback

sources:
  - include_dirs:
      - .
    files:
      - uart_pkg.sv
      - rx_bit_if.sv
      - uart_tx.sv
      - rx_sampler.sv
      - rx_deframer.sv
      - uart_loopback.sv
      - target: test
        files:
          - tb_uart_loopback.sv
